// File: hw/pc060_pkg.sv
// Shared types and register map for the PC060 main/sound communication chip.
// Both CPU ports, the mailbox RAM and the testbench use these definitions.
// Pointer values 0-3 select data nibbles, 4-6 act on the per-side flag,
// and any other value is a status-only register.

`default_nettype none

package pc060_pkg;

    // two mailbox slots per direction, two nibbles each
    localparam int NUM_SLOTS = 2;

    // data word on either CPU bus and in the mailbox RAM
    typedef logic [3:0] nibble_t;

    // one bit per mailbox slot
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    // register map, selected by the pointer
    typedef enum logic [3:0] {
        REG_SLOT0_LO  = 4'd0,
        REG_SLOT0_HI  = 4'd1,
        REG_SLOT1_LO  = 4'd2,
        REG_SLOT1_HI  = 4'd3,
        // flag control, status is returned on reads
        REG_FLAG_LOAD = 4'd4,
        REG_FLAG_SET  = 4'd5,
        REG_FLAG_CLR  = 4'd6
    } pc060_reg_e;

endpackage

`default_nettype wire

// File: hw/pc060_port.sv
// One CPU side of the PC060: register pointer, end-of-access detection,
// mailbox full bits and the side's control flag.
// Instantiated once for the main CPU and once for the sound CPU. The full
// request of each side feeds the set_full input of the other side.

`timescale 1ns/1ps
`default_nettype none

module pc060_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cs,
    input  logic                  addr,
    input  logic                  we,
    input  pc060_pkg::nibble_t    wdata,
    input  pc060_pkg::slot_mask_t set_full,
    input  pc060_pkg::slot_mask_t other_full,
    output logic                  ram_we,
    output logic [3:0]            ptr,
    output pc060_pkg::slot_mask_t full_rq,
    output pc060_pkg::slot_mask_t is_full,
    output logic                  flag
);
    import pc060_pkg::*;

    // registered bus state of the current access
    logic    cs_q;
    logic    we_q;
    logic    addr_q;
    nibble_t wdata_q;

    logic    access_end;
    logic    ptr_load;
    logic    ptr_data;

    //////////////////////////////////////////////////
    // access decode
    //////////////////////////////////////////////////

    // pointer inside the data nibbles
    assign ptr_data   = (ptr < REG_FLAG_LOAD);

    // RAM write follows the live bus, held for the whole cs-high window
    assign ram_we     = cs & we & addr & ptr_data;

    // first cs-low cycle after a high one
    assign access_end = cs_q & ~cs;

    // write to address 0 loads the pointer
    assign ptr_load   = we_q & ~addr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q <= 1'b0;
        end else begin
            cs_q <= cs;
        end
    end

    // capture the access while cs is high
    // values stay put through the access-end cycle
    always_ff @(posedge clk) begin
        if (cs) begin
            we_q    <= we;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // pointer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (access_end) begin
            if (ptr_load) begin
                ptr <= wdata_q;
            end else if (ptr_data) begin
                // auto increment through the data nibbles only
                ptr <= ptr + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // full bits
    //////////////////////////////////////////////////

    // full_rq: request to the other side, dropped once it shows full
    // is_full: set by the other side, cleared by our own read
    always_ff @(posedge clk) begin
        if (rst) begin
            full_rq <= '0;
            is_full <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (other_full[i]) begin
                    full_rq[i] <= 1'b0;
                end
                if (set_full[i]) begin
                    is_full[i] <= 1'b1;
                end
            end
            // access end takes priority over the handshake above
            if (access_end && !ptr_load) begin
                case (ptr)
                    REG_SLOT0_HI: begin
                        if (we_q) begin
                            full_rq[0] <= 1'b1;
                        end else begin
                            is_full[0] <= 1'b0;
                        end
                    end
                    REG_SLOT1_HI: begin
                        if (we_q) begin
                            full_rq[1] <= 1'b1;
                        end else begin
                            is_full[1] <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // control flag
    //////////////////////////////////////////////////

    // main side: sound CPU reset, sound side: NMI mask
    always_ff @(posedge clk) begin
        if (rst) begin
            flag <= 1'b0;
        end else if (access_end && !ptr_load) begin
            case (ptr)
                REG_FLAG_LOAD: begin
                    // only a write carries a value
                    if (we_q) begin
                        flag <= wdata_q[0];
                    end
                end
                REG_FLAG_SET: flag <= 1'b1;
                REG_FLAG_CLR: flag <= 1'b0;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/pc060_mailbox_ram.sv
// Mailbox storage for the PC060: one bank of data nibbles per direction.
// The main CPU writes the to-sound bank and reads the to-main bank, the
// sound CPU does the reverse. Read data is registered, one cycle after
// the pointer settles. Contents are undefined until written.

`timescale 1ns/1ps
`default_nettype none

module pc060_mailbox_ram (
    input  logic               clk,
    input  logic               main_we,
    input  logic [1:0]         main_ptr,
    input  pc060_pkg::nibble_t main_wdata,
    input  logic               snd_we,
    input  logic [1:0]         snd_ptr,
    input  pc060_pkg::nibble_t snd_wdata,
    output pc060_pkg::nibble_t main_q,
    output pc060_pkg::nibble_t snd_q
);
    import pc060_pkg::*;

    // two nibbles per slot
    localparam int DEPTH = 2 * NUM_SLOTS;

    nibble_t to_snd  [DEPTH];
    nibble_t to_main [DEPTH];

    //////////////////////////////////////////////////
    // main side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (main_we) begin
            to_snd[main_ptr] <= main_wdata;
        end
        main_q <= to_main[main_ptr];
    end

    //////////////////////////////////////////////////
    // sound side
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (snd_we) begin
            to_main[snd_ptr] <= snd_wdata;
        end
        snd_q <= to_snd[snd_ptr];
    end

endmodule

`default_nettype wire

// File: hw/pc060_comm.sv
// PC060 communication chip between a main CPU and a sound CPU.
// Each CPU sees a two-address nibble port: address 0 loads the pointer,
// address 1 accesses the register it selects. Pointers 4 and above read
// back a status nibble of both sides' full bits. Also drives the sound
// CPU reset and the active-low sound NMI.

`timescale 1ns/1ps
`default_nettype none

module pc060_comm (
    input  logic               clk,
    input  logic               rst,
    // main CPU bus
    input  logic               main_cs,
    input  logic               main_addr,
    input  logic               main_rnw,
    input  pc060_pkg::nibble_t main_wdata,
    output pc060_pkg::nibble_t main_rdata,
    // sound CPU bus
    input  logic               snd_cs,
    input  logic               snd_addr,
    input  logic               snd_rnw,
    input  pc060_pkg::nibble_t snd_wdata,
    output pc060_pkg::nibble_t snd_rdata,
    // sound CPU control
    output logic               snd_nmi_n,
    output logic               snd_rst
);
    import pc060_pkg::*;

    logic       main_we;
    logic       snd_we;
    logic       main_ram_we;
    logic       snd_ram_we;
    logic [3:0] main_ptr;
    logic [3:0] snd_ptr;
    logic       main_flag;
    logic       snd_flag;

    // requests toward the other side, and each side's own full bits
    slot_mask_t main_full_rq;
    slot_mask_t snd_full_rq;
    slot_mask_t main_full;
    slot_mask_t snd_full;

    nibble_t    main_q;
    nibble_t    snd_q;
    nibble_t    status;

    assign main_we = ~main_rnw;
    assign snd_we  = ~snd_rnw;

    //////////////////////////////////////////////////
    // CPU ports
    //////////////////////////////////////////////////

    pc060_port u_main (
        .clk        (clk),
        .rst        (rst),
        .cs         (main_cs),
        .addr       (main_addr),
        .we         (main_we),
        .wdata      (main_wdata),
        .set_full   (snd_full_rq),
        .other_full (snd_full),
        .ram_we     (main_ram_we),
        .ptr        (main_ptr),
        .full_rq    (main_full_rq),
        .is_full    (main_full),
        .flag       (main_flag)
    );

    pc060_port u_snd (
        .clk        (clk),
        .rst        (rst),
        .cs         (snd_cs),
        .addr       (snd_addr),
        .we         (snd_we),
        .wdata      (snd_wdata),
        .set_full   (main_full_rq),
        .other_full (main_full),
        .ram_we     (snd_ram_we),
        .ptr        (snd_ptr),
        .full_rq    (snd_full_rq),
        .is_full    (snd_full),
        .flag       (snd_flag)
    );

    //////////////////////////////////////////////////
    // mailbox storage
    //////////////////////////////////////////////////

    // ram_we implies a data pointer, low two bits pick the nibble
    pc060_mailbox_ram u_ram (
        .clk        (clk),
        .main_we    (main_ram_we),
        .main_ptr   (main_ptr[1:0]),
        .main_wdata (main_wdata),
        .snd_we     (snd_ram_we),
        .snd_ptr    (snd_ptr[1:0]),
        .snd_wdata  (snd_wdata),
        .main_q     (main_q),
        .snd_q      (snd_q)
    );

    //////////////////////////////////////////////////
    // read data and sound control
    //////////////////////////////////////////////////

    // main full bits on top, sound full bits below
    assign status     = {main_full, snd_full};

    assign main_rdata = (main_ptr >= REG_FLAG_LOAD) ? status : main_q;
    assign snd_rdata  = (snd_ptr >= REG_FLAG_LOAD) ? status : snd_q;

    assign snd_rst    = main_flag;

    // NMI pending while unmasked and any sound slot is full
    assign snd_nmi_n  = snd_flag | ~(|snd_full);

endmodule

`default_nettype wire

// File: tests/pc060_checker.sv
// Concurrent assertions for one CPU side of the PC060 chip.
// Bound into every pc060_port instance, so the main and sound sides are
// both covered without touching the RTL.

`timescale 1ns/1ps
`default_nettype none

module pc060_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  ram_we,
    input logic [3:0]            ptr,
    input pc060_pkg::slot_mask_t set_full,
    input pc060_pkg::slot_mask_t other_full,
    input pc060_pkg::slot_mask_t full_rq,
    input pc060_pkg::slot_mask_t is_full,
    input logic                  flag
);
    import pc060_pkg::*;

    // RAM writes only land on data nibbles
    a_ram_we_ptr: assert property (@(posedge clk) disable iff (rst)
        ram_we |-> ptr < 4'd4)
        else $error("ram_we high with pointer %0d", ptr);

    // flag comes out of reset cleared
    a_flag_reset: assert property (@(posedge clk) rst |=> !flag)
        else $error("flag set in the cycle after reset");

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        // full bit only set by the other side's request
        a_full_rise: assert property (@(posedge clk) disable iff (rst)
            $rose(is_full[i]) |-> $past(set_full[i]))
            else $error("is_full[%0d] rose without set_full", i);

        // request dropped once the other side shows full
        a_rq_fall: assert property (@(posedge clk) disable iff (rst)
            full_rq[i] && other_full[i] |=> !full_rq[i])
            else $error("full_rq[%0d] still high after other_full", i);
    end

endmodule

bind pc060_port pc060_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .ram_we     (ram_we),
    .ptr        (ptr),
    .set_full   (set_full),
    .other_full (other_full),
    .full_rq    (full_rq),
    .is_full    (is_full),
    .flag       (flag)
);

`default_nettype wire

// File: tests/tb_pc060.sv
// Testbench for the PC060 communication chip.
// Drives both CPU buses, keeps a reference model of the mailbox, full bits,
// flags and pointers, and compares every access in a separate process.
// Prints one line per test and a closing summary.

`timescale 1ns/1ps
`default_nettype none

module tb_pc060;
    import pc060_pkg::*;

    localparam int POLL_LIMIT = 50;
    localparam bit MAIN = 1'b0;
    localparam bit SND  = 1'b1;

    // one queued comparison, ctl is {snd_rst, snd_nmi_n}
    typedef struct packed {
        logic       is_read;
        nibble_t    exp_rd;
        nibble_t    got_rd;
        logic [1:0] exp_ctl;
        logic [1:0] got_ctl;
    } check_t;

    logic    clk;
    logic    rst;
    logic    main_cs;
    logic    main_addr;
    logic    main_rnw;
    nibble_t main_wdata;
    nibble_t main_rdata;
    logic    snd_cs;
    logic    snd_addr;
    logic    snd_rnw;
    nibble_t snd_wdata;
    nibble_t snd_rdata;
    logic    snd_nmi_n;
    logic    snd_rst;

    // reference model
    nibble_t    ref_to_snd [4];
    nibble_t    ref_to_main [4];
    slot_mask_t ref_main_full;
    slot_mask_t ref_snd_full;
    logic       ref_main_flag;
    logic       ref_snd_flag;
    logic [3:0] ref_main_ptr;
    logic [3:0] ref_snd_ptr;

    check_t check_q [$];
    string  cur_name;
    int     test_errors;
    int     errors;
    int     tests_run;
    int     tests_failed;
    integer seed;

    pc060_comm u_dut (
        .clk (clk), .rst (rst),
        .main_cs (main_cs), .main_addr (main_addr), .main_rnw (main_rnw),
        .main_wdata (main_wdata), .main_rdata (main_rdata),
        .snd_cs (snd_cs), .snd_addr (snd_addr), .snd_rnw (snd_rnw),
        .snd_wdata (snd_wdata), .snd_rdata (snd_rdata),
        .snd_nmi_n (snd_nmi_n), .snd_rst (snd_rst)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // {rdata of a read now, status, snd_rst, snd_nmi_n}
    function automatic logic [9:0] pc060_expect(input logic side);
        logic [3:0] p;
        nibble_t    status;
        nibble_t    rd;
        logic       nmi_active;
        p = side ? ref_snd_ptr : ref_main_ptr;
        status = {ref_main_full, ref_snd_full};
        if (p >= 4'd4) begin
            rd = status;
        end else begin
            rd = side ? ref_to_snd[p[1:0]] : ref_to_main[p[1:0]];
        end
        // NMI when unmasked and something waits for the sound CPU
        nmi_active = !ref_snd_flag && (ref_snd_full != 2'b00);
        return {rd, status, ref_main_flag, !nmi_active};
    endfunction

    task automatic model_update(input logic side, input logic addr, input logic rnw,
                                input nibble_t wdata);
        logic [3:0] p;
        logic       slot;
        logic       flag;
        p = side ? ref_snd_ptr : ref_main_ptr;
        flag = side ? ref_snd_flag : ref_main_flag;
        slot = p[1];
        if (!rnw && !addr) begin
            p = wdata;
        end else begin
            if (!rnw && addr && p < 4'd4) begin
                if (side) ref_to_main[p[1:0]] = wdata;
                else ref_to_snd[p[1:0]] = wdata;
            end
            // high nibble finishes a slot
            if (p == 4'd1 || p == 4'd3) begin
                if (!rnw && side) ref_main_full[slot] = 1'b1;
                if (!rnw && !side) ref_snd_full[slot] = 1'b1;
                if (rnw && side) ref_snd_full[slot] = 1'b0;
                if (rnw && !side) ref_main_full[slot] = 1'b0;
            end
            if (p == 4'd4 && !rnw) flag = wdata[0];
            if (p == 4'd5) flag = 1'b1;
            if (p == 4'd6) flag = 1'b0;
            if (p < 4'd4) p = p + 4'd1;
        end
        if (side) begin
            ref_snd_ptr = p;
            ref_snd_flag = flag;
        end else begin
            ref_main_ptr = p;
            ref_main_flag = flag;
        end
    endtask

    //////////////////////////////////////////////////
    // bus tasks
    //////////////////////////////////////////////////

    // called 1 ns after a rising edge, returns at the same point
    task automatic bus_cycle(input logic side, input logic addr, input logic rnw,
                             input nibble_t wdata, output nibble_t rdata);
        if (side) begin
            {snd_cs, snd_addr, snd_rnw, snd_wdata} = {1'b1, addr, rnw, wdata};
        end else begin
            {main_cs, main_addr, main_rnw, main_wdata} = {1'b1, addr, rnw, wdata};
        end
        @(posedge clk);
        #1;
        // last cs-high cycle
        rdata = side ? snd_rdata : main_rdata;
        @(posedge clk);
        #1;
        if (side) snd_cs = 1'b0;
        else main_cs = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic queue_check(input logic is_read, input nibble_t exp_rd,
                               input nibble_t got_rd);
        logic [9:0] exp;
        exp = pc060_expect(MAIN);
        check_q.push_back({is_read, exp_rd, got_rd, exp[1:0], {snd_rst, snd_nmi_n}});
    endtask

    task automatic bus_write(input logic side, input logic addr, input nibble_t data);
        nibble_t rd;
        bus_cycle(side, addr, 1'b0, data, rd);
        model_update(side, addr, 1'b0, data);
        queue_check(1'b0, 4'd0, 4'd0);
    endtask

    task automatic bus_read(input logic side, input logic addr, output nibble_t data);
        logic [9:0] exp;
        exp = pc060_expect(side);
        bus_cycle(side, addr, 1'b1, 4'd0, data);
        model_update(side, addr, 1'b1, 4'd0);
        queue_check(1'b1, exp[9:6], data);
    endtask

    //////////////////////////////////////////////////
    // waits and reporting
    //////////////////////////////////////////////////

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s in test %s",
                 POLL_LIMIT, what, cur_name);
        $display("Test failed");
        $finish;
    endtask

    // poll status at pointer 7 until it matches the model
    task automatic wait_status(input logic side);
        logic [9:0] exp;
        nibble_t    rd;
        int         n;
        bus_write(side, 1'b0, 4'd7);
        exp = pc060_expect(side);
        n = 0;
        bus_cycle(side, 1'b1, 1'b1, 4'd0, rd);
        while (rd != exp[5:2]) begin
            if (n >= POLL_LIMIT) report_timeout("status");
            bus_cycle(side, 1'b1, 1'b1, 4'd0, rd);
            n = n + 4;
        end
        bus_read(side, 1'b1, rd);
    endtask

    task automatic wait_nmi(input logic level);
        int n;
        n = 0;
        while (snd_nmi_n != level) begin
            if (n >= POLL_LIMIT) report_timeout("snd_nmi_n");
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        int n;
        n = 0;
        while (check_q.size() != 0) begin
            if (n >= POLL_LIMIT) report_timeout("the compare process");
            @(posedge clk);
            #1;
            n++;
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors += test_errors;
        $display("test %0d %s: %s, %0d errors", tests_run, cur_name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
    endtask

    // compare process, drains queued checks on the falling edge
    initial begin : compare
        check_t c;
        forever begin
            @(negedge clk);
            while (check_q.size() != 0) begin
                c = check_q.pop_front();
                if (c.is_read) begin
                    assert (c.got_rd == c.exp_rd) else begin
                        $display("Error at %0t: rdata %h, expected %h",
                                 $time, c.got_rd, c.exp_rd);
                        test_errors++;
                    end
                end
                assert (c.got_ctl == c.exp_ctl) else begin
                    $display("Error at %0t: {snd_rst, snd_nmi_n} %b, expected %b",
                             $time, c.got_ctl, c.exp_ctl);
                    test_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin : stimulus
        nibble_t rd;
        logic    dir;
        logic    slot;
        seed = 66493;
        {rst, main_cs, main_addr, main_rnw, main_wdata} = {1'b1, 1'b0, 1'b0, 1'b1, 4'd0};
        {snd_cs, snd_addr, snd_rnw, snd_wdata} = {1'b0, 1'b0, 1'b1, 4'd0};
        {ref_main_full, ref_snd_full, ref_main_flag, ref_snd_flag} = '0;
        {ref_main_ptr, ref_snd_ptr} = '0;
        for (int i = 0; i < 4; i++) begin
            ref_to_snd[i] = 4'd0;
            ref_to_main[i] = 4'd0;
        end
        {test_errors, errors, tests_run, tests_failed} = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset state");
        wait_status(MAIN);
        wait_status(SND);
        end_test();

        begin_test("main to sound, slot 0");
        bus_write(MAIN, 1'b0, 4'd0);
        bus_write(MAIN, 1'b1, 4'h5);
        bus_write(MAIN, 1'b1, 4'hA);
        wait_status(SND);
        wait_nmi(1'b0);
        bus_write(SND, 1'b0, 4'd0);
        bus_read(SND, 1'b1, rd);
        bus_read(SND, 1'b1, rd);
        wait_nmi(1'b1);
        wait_status(SND);
        end_test();

        begin_test("sound to main, slot 1");
        bus_write(SND, 1'b0, 4'd2);
        bus_write(SND, 1'b1, 4'hC);
        bus_write(SND, 1'b1, 4'h3);
        wait_status(MAIN);
        bus_write(MAIN, 1'b0, 4'd2);
        bus_read(MAIN, 1'b1, rd);
        bus_read(MAIN, 1'b1, rd);
        wait_status(MAIN);
        end_test();

        begin_test("sound reset control");
        bus_write(MAIN, 1'b0, 4'd5);
        bus_read(MAIN, 1'b1, rd);
        bus_write(MAIN, 1'b0, 4'd6);
        bus_write(MAIN, 1'b1, 4'd0);
        // pointer stays at 4, bit 0 of each write lands in the flag
        bus_write(MAIN, 1'b0, 4'd4);
        bus_write(MAIN, 1'b1, 4'hB);
        bus_write(MAIN, 1'b1, 4'h6);
        end_test();

        begin_test("nmi mask");
        bus_write(SND, 1'b0, 4'd5);
        bus_write(SND, 1'b1, 4'd0);
        bus_write(MAIN, 1'b0, 4'd2);
        bus_write(MAIN, 1'b1, 4'h9);
        bus_write(MAIN, 1'b1, 4'h4);
        wait_status(SND);
        bus_write(SND, 1'b0, 4'd6);
        bus_write(SND, 1'b1, 4'd0);
        wait_nmi(1'b0);
        bus_write(SND, 1'b0, 4'd2);
        bus_read(SND, 1'b1, rd);
        bus_read(SND, 1'b1, rd);
        wait_nmi(1'b1);
        end_test();

        begin_test("random traffic");
        for (int i = 0; i < 40; i++) begin
            dir = 1'($random(seed));
            slot = 1'($random(seed));
            bus_write(dir, 1'b0, {2'b00, slot, 1'b0});
            bus_write(dir, 1'b1, 4'($random(seed)));
            bus_write(dir, 1'b1, 4'($random(seed)));
            // reader sees the slot full, then drains it
            wait_status(~dir);
            bus_write(~dir, 1'b0, {2'b00, slot, 1'b0});
            bus_read(~dir, 1'b1, rd);
            bus_read(~dir, 1'b1, rd);
            wait_status(~dir);
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/pc060_pkg.sv
hw/pc060_port.sv
hw/pc060_mailbox_ram.sv
hw/pc060_comm.sv
tests/pc060_checker.sv
tests/tb_pc060.sv

// File: Makefile
# Verilator lint and simulation of the PC060 communication chip.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_pc060
RTL_TOP   ?= pc060_comm
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then with the testbench
lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		hw/pc060_pkg.sv hw/pc060_port.sv hw/pc060_mailbox_ram.sv hw/pc060_comm.sv $(VFLAGS)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP) $(VFLAGS)

# the log decides, not the exit status of the run
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) && echo "PASS: $(TOP)" || \
		(echo "FAIL: $(TOP), see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
